//--- verilog/cache_cfg.svh
// sizes for a 2-way cache of 4-word lines; the package types are built from these values
`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

// ------------------------------------------------------------------------
// processor side
// ------------------------------------------------------------------------
`define CACHE_ADDR_W 30   // word address without the byte offset
`define CACHE_WORD_W 32

// ------------------------------------------------------------------------
// line and array geometry
// ------------------------------------------------------------------------
`define CACHE_LINE_W 128
`define CACHE_WORDS  4
`define CACHE_SETS   4
`define CACHE_TAG_W  26   // addr width minus index and offset bits
`define MEM_ADDR_W   28   // line address seen by slow memory

`endif

//--- verilog/cache_types_pkg.sv
// field widths assume the 26/2/2 address split given by the cfg macros
`include "cache_cfg.svh"

package cache_types_pkg;

	localparam int INDEX_W  = $clog2(`CACHE_SETS);
	localparam int OFFSET_W = $clog2(`CACHE_WORDS);

	// processor word address
	typedef struct packed {
		logic [`CACHE_TAG_W-1:0] tag;
		logic [INDEX_W-1:0]      index;
		logic [OFFSET_W-1:0]     offset;
	} word_addr_t;

	// memory moves the flat line, processor picks single words
	typedef union packed {
		logic [`CACHE_LINE_W-1:0]                    flat;
		logic [`CACHE_WORDS-1:0][`CACHE_WORD_W-1:0]  word;
	} cache_line_u;

	typedef struct packed {
		logic                    valid;
		logic                    dirty;   // unused on the instruction side
		logic [`CACHE_TAG_W-1:0] tag;
		cache_line_u             line;
	} way_entry_t;

	typedef enum logic [1:0] {
		state_compare    = 2'b00,
		state_write_back = 2'b01,
		state_allocate   = 2'b10,
		state_idle       = 2'b11
	} cache_state_e;

endpackage

//--- verilog/mem_bus_pkg.sv
// line addresses carry no word offset; only two requesters are arbitrated
`include "cache_cfg.svh"

package mem_bus_pkg;

	// tag followed by set index
	typedef struct packed {
		logic [`CACHE_TAG_W-1:0]             tag;
		logic [`MEM_ADDR_W-`CACHE_TAG_W-1:0] index;
	} mem_line_addr_t;

	typedef enum logic [1:0] {
		owner_none   = 2'd0,
		owner_icache = 2'd1,
		owner_dcache = 2'd2
	} mem_owner_e;

endpackage

//--- verilog/mem_req_if.sv
// one line-wide request at a time; request held until a single ready pulse
`timescale 1ns/100ps
`include "cache_cfg.svh"

interface mem_req_if;
	import mem_bus_pkg::*;

	logic                     read;
	logic                     write;
	mem_line_addr_t           addr;
	logic [`CACHE_LINE_W-1:0] wdata;
	logic [`CACHE_LINE_W-1:0] rdata;   // valid in the ready cycle
	logic                     ready;

	modport cache   (output read, write, addr, wdata, input rdata, ready);
	modport arbiter (input read, write, addr, wdata, output rdata, ready);

endinterface

//--- verilog/icache.sv
// read-only cache; proc_addr must stay stable while proc_stall is high
`timescale 1ns/100ps
`include "cache_cfg.svh"

module icache (
	input  logic                        clk,
	input  logic                        proc_reset,
	input  logic                        proc_read,
	input  cache_types_pkg::word_addr_t proc_addr,
	output logic [`CACHE_WORD_W-1:0]    proc_rdata,
	output logic                        proc_stall,
	mem_req_if.cache                    mem
);
	import cache_types_pkg::*;
	import mem_bus_pkg::*;

	way_entry_t             ways [2][`CACHE_SETS];
	logic [`CACHE_SETS-1:0] lru;   // way to refill next, per set
	cache_state_e           state, state_nxt;
	way_entry_t             way0, way1, fill;
	logic                   hit0, hit1, miss;

	assign way0 = ways[0][proc_addr.index];
	assign way1 = ways[1][proc_addr.index];
	assign hit0 = way0.valid && (way0.tag == proc_addr.tag);
	assign hit1 = way1.valid && (way1.tag == proc_addr.tag);
	assign miss = proc_read && !(hit0 || hit1);

	assign proc_rdata = hit1 ? way1.line.word[proc_addr.offset]
	                         : way0.line.word[proc_addr.offset];

	// refill entry built straight from the memory line
	always_comb begin
		fill.valid     = 1'b1;
		fill.dirty     = 1'b0;
		fill.tag       = proc_addr.tag;
		fill.line.flat = mem.rdata;
	end

	assign mem.write = 1'b0;
	assign mem.wdata = '0;
	assign mem.addr  = mem_line_addr_t'{tag: proc_addr.tag, index: proc_addr.index};

	// ------------------------------------------------------------------------
	// control FSM
	// ------------------------------------------------------------------------
	always_comb begin
		state_nxt  = state;
		proc_stall = 1'b0;
		mem.read   = 1'b0;
		case (state)
			state_idle: begin
				state_nxt  = state_compare;
				proc_stall = proc_read;   // lookup starts next cycle
			end
			state_compare: begin
				proc_stall = miss;
				if (miss) begin
					state_nxt = state_allocate;
				end
			end
			state_allocate: begin
				proc_stall = 1'b1;
				mem.read   = 1'b1;   // held through the ready cycle
				if (mem.ready) begin
					state_nxt = state_compare;
				end
			end
			default: state_nxt = state_idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (proc_reset) begin
			state <= state_idle;
			lru   <= '0;
			for (int s = 0; s < `CACHE_SETS; s++) begin
				ways[0][s].valid <= 1'b0;
				ways[1][s].valid <= 1'b0;
			end
		end else begin
			state <= state_nxt;
			if (state == state_allocate && mem.ready) begin
				ways[lru[proc_addr.index]][proc_addr.index] <= fill;
				lru[proc_addr.index] <= ~lru[proc_addr.index];
			end
		end
	end

	// never writes, and the arbiter only hands ready to a live request
	a_read_only: assert property (@(posedge clk) disable iff (proc_reset)
		!mem.write && (mem.ready -> mem.read));

endmodule

//--- verilog/dcache.sv
// write-back, write-allocate; processor inputs must hold while proc_stall is high
`timescale 1ns/100ps
`include "cache_cfg.svh"

module dcache (
	input  logic                        clk,
	input  logic                        proc_reset,
	input  logic                        proc_read,
	input  logic                        proc_write,
	input  cache_types_pkg::word_addr_t proc_addr,
	input  logic [`CACHE_WORD_W-1:0]    proc_wdata,
	output logic [`CACHE_WORD_W-1:0]    proc_rdata,
	output logic                        proc_stall,
	mem_req_if.cache                    mem
);
	import cache_types_pkg::*;
	import mem_bus_pkg::*;

	way_entry_t             ways [2][`CACHE_SETS];
	logic [`CACHE_SETS-1:0] lru;   // victim way per set
	cache_state_e           state, state_nxt;
	way_entry_t             way0, way1, victim, fill;
	logic                   hit0, hit1, req, miss;
	logic                   victim_way;

	assign way0 = ways[0][proc_addr.index];
	assign way1 = ways[1][proc_addr.index];
	assign hit0 = way0.valid && (way0.tag == proc_addr.tag);
	assign hit1 = way1.valid && (way1.tag == proc_addr.tag);
	assign req  = proc_read || proc_write;
	assign miss = req && !(hit0 || hit1);

	assign victim_way = lru[proc_addr.index];
	assign victim     = victim_way ? way1 : way0;

	assign proc_rdata = hit1 ? way1.line.word[proc_addr.offset]
	                         : way0.line.word[proc_addr.offset];

	always_comb begin
		fill.valid     = 1'b1;
		fill.dirty     = 1'b0;
		fill.tag       = proc_addr.tag;
		fill.line.flat = mem.rdata;
	end

	// ------------------------------------------------------------------------
	// control FSM and memory request
	// ------------------------------------------------------------------------
	always_comb begin
		state_nxt  = state;
		proc_stall = 1'b0;
		mem.read   = 1'b0;
		mem.write  = 1'b0;
		mem.addr   = mem_line_addr_t'{tag: proc_addr.tag, index: proc_addr.index};
		mem.wdata  = victim.line.flat;
		case (state)
			state_idle: begin
				state_nxt  = state_compare;
				proc_stall = req;
			end
			state_compare: begin
				proc_stall = miss;
				if (miss) begin
					state_nxt = (victim.valid && victim.dirty) ? state_write_back
					                                           : state_allocate;
				end
			end
			state_write_back: begin
				proc_stall = 1'b1;
				mem.write  = 1'b1;
				mem.addr   = mem_line_addr_t'{tag: victim.tag, index: proc_addr.index};
				if (mem.ready) begin
					state_nxt = state_allocate;
				end
			end
			state_allocate: begin
				proc_stall = 1'b1;
				mem.read   = 1'b1;
				if (mem.ready) begin
					state_nxt = state_compare;   // retry as a hit
				end
			end
			default: state_nxt = state_idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (proc_reset) begin
			state <= state_idle;
			lru   <= '0;
			for (int s = 0; s < `CACHE_SETS; s++) begin
				ways[0][s].valid <= 1'b0;
				ways[0][s].dirty <= 1'b0;
				ways[1][s].valid <= 1'b0;
				ways[1][s].dirty <= 1'b0;
			end
		end else begin
			state <= state_nxt;
			case (state)
				state_compare: begin
					if (proc_write && (hit0 || hit1)) begin
						ways[hit1][proc_addr.index].line.word[proc_addr.offset] <= proc_wdata;
						ways[hit1][proc_addr.index].dirty <= 1'b1;
					end
				end
				state_write_back: begin
					if (mem.ready) begin
						ways[victim_way][proc_addr.index].dirty <= 1'b0;   // now clean
					end
				end
				state_allocate: begin
					if (mem.ready) begin
						ways[victim_way][proc_addr.index] <= fill;
						lru[proc_addr.index] <= ~victim_way;
					end
				end
				default: ;
			endcase
		end
	end

	// ready only ever answers a request raised in one direction
	a_one_dir: assert property (@(posedge clk) disable iff (proc_reset)
		!(mem.read && mem.write) && (mem.ready -> (mem.read || mem.write)));

	// waiting request keeps its line address until ready
	a_addr_hold: assert property (@(posedge clk) disable iff (proc_reset)
		(mem.read || mem.write) && !mem.ready |=> $stable(mem.addr));

endmodule

//--- verilog/mem_arbiter.sv
// two requesters, round-robin after each completed transfer; no queueing
`timescale 1ns/100ps
`include "cache_cfg.svh"

module mem_arbiter (
	input  logic                        clk,
	input  logic                        proc_reset,
	mem_req_if.arbiter                  icache_mem,
	mem_req_if.arbiter                  dcache_mem,
	output logic                        mem_read,
	output logic                        mem_write,
	output mem_bus_pkg::mem_line_addr_t mem_addr,
	output logic [`CACHE_LINE_W-1:0]    mem_wdata,
	input  logic [`CACHE_LINE_W-1:0]    mem_rdata,
	input  logic                        mem_ready
);
	import mem_bus_pkg::*;

	mem_owner_e owner, sel;
	logic       last_dcache;   // set when dcache was served last
	logic       i_req, d_req;

	assign i_req = icache_mem.read || icache_mem.write;
	assign d_req = dcache_mem.read || dcache_mem.write;

	// grant is combinational when idle, so the first cycle is not lost
	always_comb begin
		if (owner != owner_none) sel = owner;
		else if (i_req && d_req) sel = last_dcache ? owner_icache : owner_dcache;
		else if (i_req)          sel = owner_icache;
		else if (d_req)          sel = owner_dcache;
		else                     sel = owner_none;
	end

	always_comb begin
		mem_read  = 1'b0;
		mem_write = 1'b0;
		mem_addr  = '0;
		mem_wdata = '0;
		case (sel)
			owner_icache: begin
				mem_read  = icache_mem.read;
				mem_write = icache_mem.write;
				mem_addr  = icache_mem.addr;
				mem_wdata = icache_mem.wdata;
			end
			owner_dcache: begin
				mem_read  = dcache_mem.read;
				mem_write = dcache_mem.write;
				mem_addr  = dcache_mem.addr;
				mem_wdata = dcache_mem.wdata;
			end
			default: ;
		endcase
	end

	assign icache_mem.rdata = mem_rdata;
	assign dcache_mem.rdata = mem_rdata;
	assign icache_mem.ready = mem_ready && (sel == owner_icache);   // others keep stalling
	assign dcache_mem.ready = mem_ready && (sel == owner_dcache);

	always_ff @(posedge clk) begin
		if (proc_reset) begin
			owner       <= owner_none;
			last_dcache <= 1'b0;
		end else if (mem_ready && sel != owner_none) begin
			owner       <= owner_none;
			last_dcache <= (sel == owner_dcache);
		end else begin
			owner <= sel;
		end
	end

	// a grant and its raised request both hold until the ready cycle
	a_grant_hold: assert property (@(posedge clk) disable iff (proc_reset)
		(sel != owner_none) && !mem_ready |=> (sel == $past(sel)) && (mem_read || mem_write));

endmodule

//--- verilog/cache_subsystem.sv
// both caches share one slow-memory port; processor ports hold while stalled
`timescale 1ns/100ps
`include "cache_cfg.svh"

module cache_subsystem (
	input  logic                     clk,
	input  logic                     proc_reset,
	// instruction side
	input  logic                     i_read,
	input  logic [`CACHE_ADDR_W-1:0] i_addr,
	output logic [`CACHE_WORD_W-1:0] i_rdata,
	output logic                     i_stall,
	// data side
	input  logic                     d_read,
	input  logic                     d_write,
	input  logic [`CACHE_ADDR_W-1:0] d_addr,
	input  logic [`CACHE_WORD_W-1:0] d_wdata,
	output logic [`CACHE_WORD_W-1:0] d_rdata,
	output logic                     d_stall,
	// slow memory
	output logic                     mem_read,
	output logic                     mem_write,
	output logic [`MEM_ADDR_W-1:0]   mem_addr,
	output logic [`CACHE_LINE_W-1:0] mem_wdata,
	input  logic [`CACHE_LINE_W-1:0] mem_rdata,
	input  logic                     mem_ready
);

	mem_req_if icache_mem ();
	mem_req_if dcache_mem ();

	icache u_icache (
		.clk        (clk),
		.proc_reset (proc_reset),
		.proc_read  (i_read),
		.proc_addr  (i_addr),
		.proc_rdata (i_rdata),
		.proc_stall (i_stall),
		.mem        (icache_mem.cache)
	);

	dcache u_dcache (
		.clk        (clk),
		.proc_reset (proc_reset),
		.proc_read  (d_read),
		.proc_write (d_write),
		.proc_addr  (d_addr),
		.proc_wdata (d_wdata),
		.proc_rdata (d_rdata),
		.proc_stall (d_stall),
		.mem        (dcache_mem.cache)
	);

	mem_arbiter u_mem_arbiter (
		.clk        (clk),
		.proc_reset (proc_reset),
		.icache_mem (icache_mem.arbiter),
		.dcache_mem (dcache_mem.arbiter),
		.mem_read   (mem_read),
		.mem_write  (mem_write),
		.mem_addr   (mem_addr),
		.mem_wdata  (mem_wdata),
		.mem_rdata  (mem_rdata),
		.mem_ready  (mem_ready)
	);

endmodule

//--- tb/tb_clkgen.sv
// 10 ns clock from time zero; proc_reset high for the first 4 rising edges, released 1 ns later
`timescale 1ns/100ps

module tb_clkgen (
	output logic clk,
	output logic proc_reset
);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial begin
		proc_reset = 1'b1;
		repeat (4) @(posedge clk);
		#1 proc_reset = 1'b0;   // same offset as the stimulus
	end

endmodule

//--- tb/tb_cache_subsystem.sv
// instruction addresses stay in a region that the data side never writes
`timescale 1ns/100ps
`include "cache_cfg.svh"

module tb_cache_subsystem;

	localparam int          CYCLE_LIMIT = 200 * 20;
	localparam logic [25:0] I_TAG       = 26'h0100000;
	localparam logic [25:0] D_TAG       = 26'h0200000;

	logic                     clk, proc_reset;
	logic                     i_read, i_stall;
	logic [`CACHE_ADDR_W-1:0] i_addr;
	logic [`CACHE_WORD_W-1:0] i_rdata;
	logic                     d_read, d_write, d_stall;
	logic [`CACHE_ADDR_W-1:0] d_addr;
	logic [`CACHE_WORD_W-1:0] d_wdata, d_rdata;
	logic                     mem_read, mem_write, mem_ready;
	logic [`MEM_ADDR_W-1:0]   mem_addr;
	logic [`CACHE_LINE_W-1:0] mem_wdata, mem_rdata;

	logic [31:0]  shadow [logic [29:0]];    // expected words written by the data side
	logic [127:0] mem_lines [logic [27:0]]; // sparse slow memory
	logic [31:0]  exp_q[$], got_q[$];
	string        note_q[$];
	logic [15:0]  lfsr = 16'd81;
	int           errors, checks, cycle_count;
	int           reads_seen, writes_seen;
	logic [27:0]  last_wr_addr, i_pend_line, d_pend_line;
	logic [127:0] last_wr_line;
	logic         i_busy, d_busy;

	tb_clkgen clkgen (.clk(clk), .proc_reset(proc_reset));

	cache_subsystem dut (.*);

	// ------------------------------------------------------------------------
	// reference model and helpers
	// ------------------------------------------------------------------------
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
	endfunction

	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v    = {v[30:0], lfsr[0]};
			lfsr = lfsr_next(lfsr);   // one step per bit
		end
		return v;
	endfunction

	function automatic logic [29:0] make_addr(input logic [25:0] tag, input logic [1:0] index,
			input logic [1:0] offset);
		return {tag, index, offset};
	endfunction

	// untouched memory holds its word address xor a constant
	function automatic logic [31:0] expected_word(input logic [29:0] a);
		if (shadow.exists(a)) begin
			return shadow[a];
		end
		return {2'b00, a} ^ 32'h5a3c_9e17;
	endfunction

	function automatic logic [127:0] stored_line(input logic [27:0] la);
		logic [127:0] line;
		if (mem_lines.exists(la)) begin
			return mem_lines[la];
		end
		for (int w = 0; w < 4; w++) begin
			line[w*32 +: 32] = expected_word({la, w[1:0]});
		end
		return line;
	endfunction

	task automatic report_error(input string msg);
		errors++;
		$display("[ERROR] %0t: %s", $time, msg);
	endtask

	task automatic queue_check(input logic [31:0] exp_word, input logic [31:0] got_word,
			input string note);
		exp_q.push_back(exp_word);
		got_q.push_back(got_word);
		note_q.push_back(note);
	endtask

	// ------------------------------------------------------------------------
	// processor side accesses start 1 ns after a rising edge
	// ------------------------------------------------------------------------
	task automatic i_access(input logic [29:0] a);
		logic [31:0] got;
		logic        done;
		i_read      = 1'b1;
		i_addr      = a;
		i_pend_line = a[29:2];
		i_busy      = 1'b1;
		done        = 1'b0;
		while (!done) begin
			@(negedge clk);
			if (!i_stall) begin
				done = 1'b1;
				got  = i_rdata;
			end
			@(posedge clk);
			#1;
		end
		i_read = 1'b0;
		i_busy = 1'b0;
		queue_check(expected_word(a), got, $sformatf("instruction read %h", a));
	endtask

	task automatic d_access(input logic wr, input logic [29:0] a, input logic [31:0] wd,
			output logic [31:0] got);
		logic done;
		d_read      = !wr;
		d_write     = wr;
		d_addr      = a;
		d_wdata     = wd;
		d_pend_line = a[29:2];
		d_busy      = 1'b1;
		done        = 1'b0;
		while (!done) begin
			@(negedge clk);
			if (!d_stall) begin
				done = 1'b1;
				got  = d_rdata;
			end
			@(posedge clk);
			#1;
		end
		d_read  = 1'b0;
		d_write = 1'b0;
		d_busy  = 1'b0;
		if (wr) begin
			shadow[a] = wd;
		end else begin
			queue_check(expected_word(a), got, $sformatf("data read %h", a));
		end
	endtask

	// ------------------------------------------------------------------------
	// slow memory answers with one ready pulse 1 to 4 cycles after the request
	// ------------------------------------------------------------------------
	initial begin : memory_model
		logic [27:0]  la;
		logic [127:0] line;
		int           delay;
		mem_ready = 1'b0;
		mem_rdata = '0;
		forever begin
			@(negedge clk);
			if (mem_read && mem_write) begin
				report_error("mem_read and mem_write high together");
			end
			if (!proc_reset && (mem_read || mem_write)) begin
				la = mem_addr;
				if (mem_write) begin
					writes_seen++;
					last_wr_addr = la;
					last_wr_line = mem_wdata;
					for (int w = 0; w < 4; w++) begin   // victim must match the reference
						queue_check(expected_word({la, w[1:0]}), mem_wdata[w*32 +: 32],
							$sformatf("write-back word %h", {la, w[1:0]}));
					end
					mem_lines[la] = mem_wdata;
				end else begin
					reads_seen++;
					if (!((i_busy && la == i_pend_line) || (d_busy && la == d_pend_line))) begin
						report_error($sformatf("memory read %h matches no outstanding miss", la));
					end
				end
				line  = stored_line(la);
				delay = take_bits(2) + 1;
				repeat (delay) @(posedge clk);
				#1;
				mem_rdata = line;
				mem_ready = 1'b1;
				@(posedge clk);
				#1;
				mem_ready = 1'b0;
			end
		end
	end

	// comparing process
	initial begin : compare_results
		logic [31:0] exp_word, got_word;
		string       note;
		forever begin
			@(posedge clk);
			while (exp_q.size() > 0) begin
				exp_word = exp_q.pop_front();
				got_word = got_q.pop_front();
				note     = note_q.pop_front();
				checks++;
				if (got_word !== exp_word) begin
					report_error($sformatf("%s: expected %h, got %h", note, exp_word, got_word));
				end
			end
		end
	end

	initial begin : watchdog
		cycle_count = 0;
		while (cycle_count < CYCLE_LIMIT) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
		$display("Test failed");
		$finish;
	end

	// ------------------------------------------------------------------------
	// stimulus
	// ------------------------------------------------------------------------
	initial begin : stimulus
		logic [29:0] addr_a, addr_b, addr_c, ia;
		logic [31:0] wd, wa, got, t, s, o;
		logic        wr;
		int          rd0, wr0;
		i_read  = 1'b0;
		i_addr  = '0;
		d_read  = 1'b0;
		d_write = 1'b0;
		d_addr  = '0;
		d_wdata = '0;
		i_busy  = 1'b0;
		d_busy  = 1'b0;
		wait (proc_reset === 1'b0);
		@(posedge clk);
		#1;

		// instruction refill followed by a hit in the same line
		rd0 = reads_seen;
		i_access(make_addr(I_TAG, 2'd1, 2'd2));
		if (reads_seen != rd0 + 1) report_error("instruction miss did not read one line");
		rd0 = reads_seen;
		i_access(make_addr(I_TAG, 2'd1, 2'd3));
		if (reads_seen != rd0) report_error("instruction hit went to memory");

		// data write hit and read back
		d_access(1'b0, make_addr(D_TAG, 2'd1, 2'd0), '0, got);
		rd0 = reads_seen;
		wr0 = writes_seen;
		wd  = take_bits(32);
		d_access(1'b1, make_addr(D_TAG, 2'd1, 2'd1), wd, got);
		d_access(1'b0, make_addr(D_TAG, 2'd1, 2'd1), '0, got);
		if (got !== wd) report_error($sformatf("write hit read back %h, expected %h", got, wd));
		if (reads_seen != rd0 || writes_seen != wr0) report_error("data hits caused memory traffic");

		// dirty eviction in set 3
		addr_a = make_addr(D_TAG + 26'h10, 2'd3, 2'd0);
		wa     = take_bits(32);
		d_access(1'b1, addr_a, wa, got);
		d_access(1'b1, make_addr(D_TAG + 26'h11, 2'd3, 2'd1), take_bits(32), got);
		wr0 = writes_seen;
		d_access(1'b1, make_addr(D_TAG + 26'h12, 2'd3, 2'd2), take_bits(32), got);
		if (writes_seen != wr0 + 1) report_error("third line in set 3 gave no single write-back");
		if (last_wr_addr !== addr_a[29:2]) begin
			report_error($sformatf("write-back to %h, expected %h", last_wr_addr, addr_a[29:2]));
		end
		if (last_wr_line[31:0] !== wa) report_error("write-back line lacks the written word");
		d_access(1'b0, addr_a, '0, got);
		if (got !== wa) report_error($sformatf("evicted word read %h, expected %h", got, wa));

		// in set 2 line C must evict A
		addr_a = make_addr(D_TAG + 26'h20, 2'd2, 2'd0);
		addr_b = make_addr(D_TAG + 26'h21, 2'd2, 2'd1);
		addr_c = make_addr(D_TAG + 26'h22, 2'd2, 2'd2);
		d_access(1'b0, addr_a, '0, got);
		d_access(1'b0, addr_b, '0, got);
		d_access(1'b0, addr_c, '0, got);
		rd0 = reads_seen;
		d_access(1'b0, addr_b, '0, got);
		if (reads_seen != rd0) report_error("line B was evicted instead of A");
		d_access(1'b0, addr_a, '0, got);
		if (reads_seen != rd0 + 1) report_error("line A did not miss after C");

		// both caches miss in the same cycle
		rd0 = reads_seen;
		fork
			i_access(make_addr(I_TAG + 26'h1, 2'd0, 2'd1));
			d_access(1'b0, make_addr(D_TAG + 26'h30, 2'd0, 2'd3), '0, got);
		join
		if (reads_seen != rd0 + 2) report_error("shared port did not serve both misses");

		// random mix on both sides
		for (int n = 0; n < 150; n++) begin
			wr = 1'(take_bits(1));
			t  = take_bits(2);
			s  = take_bits(2);
			o  = take_bits(2);
			wd = take_bits(32);
			addr_a = make_addr(D_TAG + 26'h40 + t[1:0], s[1:0], o[1:0]);
			t  = take_bits(1);
			s  = take_bits(2);
			o  = take_bits(2);
			ia = make_addr(I_TAG + t[0], s[1:0], o[1:0]);
			fork
				i_access(ia);
				d_access(wr, addr_a, wd, got);
			join
		end

		repeat (2) @(posedge clk);
		#1;
		$display("compared %0d values, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

//--- vlog.f
+incdir+verilog
verilog/cache_types_pkg.sv
verilog/mem_bus_pkg.sv
verilog/mem_req_if.sv
verilog/icache.sv
verilog/dcache.sv
verilog/mem_arbiter.sv
verilog/cache_subsystem.sv
tb/tb_clkgen.sv
tb/tb_cache_subsystem.sv

//--- Bender.yml
package:
  name: cache_subsystem

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/cache_types_pkg.sv
      - verilog/mem_bus_pkg.sv
      - verilog/mem_req_if.sv
      - verilog/icache.sv
      - verilog/dcache.sv
      - verilog/mem_arbiter.sv
      - verilog/cache_subsystem.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - tb/tb_clkgen.sv
      - tb/tb_cache_subsystem.sv
